//--- include/fma_cfg.svh
/*
 * FMA configuration
 * Single-precision field widths, exponent bias and request tag width
 */
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// IEEE binary32 encoding
`define FMA_EXP_BITS 8      // Exponent field
`define FMA_MAN_BITS 23     // Mantissa field, implicit bit excluded
`define FMA_BIAS     127    // Exponent bias

// Request tag echoed with the response
`define FMA_TAG_WIDTH 4

`endif

//--- src/fp_pkg.sv
/*
 * IEEE single-precision definitions
 * Encoded value, operand classification, rounding modes and status flags
 */
`include "fma_cfg.svh"

package fp_pkg;

  localparam int EXP_BITS = `FMA_EXP_BITS;
  localparam int MAN_BITS = `FMA_MAN_BITS;
  localparam int BIAS     = `FMA_BIAS;

  // Encoded operand
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operand class, one-hot apart from is_signalling
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;    // Only together with is_nan
  } fp_info_t;

  typedef enum logic [2:0] {
    RNE = 3'd0,             // Nearest, ties to even
    RTZ = 3'd1,             // Toward zero
    RDN = 3'd2,             // Toward -inf
    RUP = 3'd3,             // Toward +inf
    RMM = 3'd4              // Nearest, ties away from zero
  } roundmode_e;

  typedef struct packed {
    logic NV;               // Invalid operation
    logic DZ;               // Divide by zero
    logic OF;               // Overflow
    logic UF;               // Underflow
    logic NX;               // Inexact
  } status_t;

  // Canonical quiet NaN, 7FC00000
  localparam fp_t CANONICAL_QNAN = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(MAN_BITS-1){1'b0}}}
  };

endpackage

//--- src/fma_pkg.sv
/*
 * FMA datapath definitions
 * Operation encoding, request and response payloads, and the state held
 * between the adder and normalization
 */
`include "fma_cfg.svh"

package fma_pkg;
  import fp_pkg::*;

  localparam int PREC_BITS   = MAN_BITS + 1;             // Mantissa with implicit bit
  localparam int SUM_WIDTH   = 3 * PREC_BITS + 4;        // Product, addend and G/R bits
  localparam int EXP_WIDTH   = EXP_BITS + 2;             // Signed internal exponent
  localparam int SHAMT_WIDTH = $clog2(3 * PREC_BITS + 4);

  // With op_mod the addend sign is flipped (FMSUB, FNMADD, SUB)
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } fma_op_e;

  typedef struct packed {
    fp_t [2:0]                 operands;    // A, B, C at index 0, 1, 2
    fma_op_e                   op;
    logic                      op_mod;
    roundmode_e                rnd_mode;
    logic [`FMA_TAG_WIDTH-1:0] tag;
  } fma_req_t;

  // ------------------------------------------------------------------------
  // State after the adder
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                      eff_sub;           // Product and addend signs differ
    logic                      final_sign;
    logic [EXP_WIDTH-1:0]      exp_product;       // Two's complement
    logic [EXP_WIDTH-1:0]      exp_diff;          // Addend minus product
    logic [EXP_WIDTH-1:0]      tent_exp;
    logic [SHAMT_WIDTH-1:0]    addend_shamt;
    logic                      sticky_before_add; // Addend bits shifted out
    logic [SUM_WIDTH-1:0]      sum;               // Magnitude of the sum
    roundmode_e                rnd_mode;
    logic                      is_special;        // Bypass the regular result
    fp_t                       special_result;
    status_t                   special_status;
    logic [`FMA_TAG_WIDTH-1:0] tag;
  } fma_mid_t;

  typedef struct packed {
    fp_t                       result;
    status_t                   status;
    logic [`FMA_TAG_WIDTH-1:0] tag;
  } fma_rsp_t;

endpackage

//--- src/fp_classifier.sv
/*
 * Operand classifier
 * Decodes exponent and mantissa fields of three operands into class bits
 */
`timescale 1ns/10ps

module fp_classifier
  import fp_pkg::*;
(
  input  fp_t      [2:0] ops_i,
  output fp_info_t [2:0] info_o
);

  for (genvar i = 0; i < 3; i++) begin : gen_ops
    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    assign exp_zero = (ops_i[i].exponent == '0);
    assign exp_ones = (ops_i[i].exponent == '1);
    assign man_zero = (ops_i[i].mantissa == '0);

    // Quiet NaNs carry a set mantissa MSB
    assign info_o[i] = '{
      is_normal:     !exp_zero && !exp_ones,
      is_subnormal:  exp_zero && !man_zero,
      is_zero:       exp_zero && man_zero,
      is_inf:        exp_ones && man_zero,
      is_nan:        exp_ones && !man_zero,
      is_signalling: exp_ones && !man_zero && !ops_i[i].mantissa[MAN_BITS-1]
    };
  end

endmodule

//--- src/fma_pipe_reg.sv
/*
 * Pipeline register stage
 * Single-entry elastic buffer with valid/ready on both sides
 */
`timescale 1ns/10ps

module fma_pipe_reg #(
  parameter type T = logic          // Payload
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  logic valid_q;
  T     data_q;

  // Free slot, or the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;             // Load next item or drain
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;               // Capture on transfer only
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

//--- src/fma_prep.sv
/*
 * FMA front end
 * Operand adjustment, special cases, exponent path, multiplier,
 * addend alignment and the wide adder
 */
`timescale 1ns/10ps

module fma_prep
  import fp_pkg::*;
  import fma_pkg::*;
(
  input  fma_req_t req_i,
  output fma_mid_t mid_o
);

  fp_info_t [2:0] info;
  fp_t            operand_a, operand_b, operand_c;
  fp_info_t       info_a, info_b, info_c;

  fp_classifier u_classifier (
    .ops_i  ( req_i.operands ),
    .info_o ( info           )
  );

  // ------------------------------------------------------------------------
  // Operation selection
  // ------------------------------------------------------------------------
  always_comb begin : op_select
    operand_a = req_i.operands[0];
    operand_b = req_i.operands[1];
    operand_c = req_i.operands[2];
    info_a    = info[0];
    info_b    = info[1];
    info_c    = info[2];
    operand_c.sign = operand_c.sign ^ req_i.op_mod;     // Modifier negates addend
    unique case (req_i.op)
      FMADD:  ;
      FNMSUB: operand_a.sign = !operand_a.sign;         // Negate product
      ADD: begin                                        // A becomes +1.0
        operand_a = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        info_a    = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin                                        // C becomes -0.0, keeps RDN sign
        operand_c = '{sign: 1'b1, exponent: '0, mantissa: '0};
        info_c    = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  logic eff_sub, tent_sign;
  assign tent_sign = operand_a.sign ^ operand_b.sign;   // Product sign
  assign eff_sub   = tent_sign ^ operand_c.sign;

  // Special cases, in priority order
  fp_t     special_result;
  status_t special_status;
  logic    is_special;

  always_comb begin : special_case
    special_result = CANONICAL_QNAN;
    special_status = '0;
    is_special     = 1'b0;
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      is_special        = 1'b1;                         // Inf * 0, whatever C is
      special_status.NV = 1'b1;
    end else if (info_a.is_nan || info_b.is_nan || info_c.is_nan) begin
      is_special        = 1'b1;
      special_status.NV = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
    end else if (info_a.is_inf || info_b.is_inf || info_c.is_inf) begin
      is_special = 1'b1;
      if ((info_a.is_inf || info_b.is_inf) && info_c.is_inf && eff_sub) begin
        special_status.NV = 1'b1;                       // Inf - inf
      end else if (info_a.is_inf || info_b.is_inf) begin
        special_result = '{sign: tent_sign, exponent: '1, mantissa: '0};
      end else begin
        special_result = '{sign: operand_c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

  // ------------------------------------------------------------------------
  // Exponent path
  // ------------------------------------------------------------------------
  logic [EXP_WIDTH-1:0]   exp_product, exp_diff, tent_exp;
  logic [SHAMT_WIDTH-1:0] addend_shamt;

  always_comb begin : exponent_path
    int e_add;
    int e_prod;
    int e_diff;
    e_add  = int'(operand_c.exponent) + int'(!info_c.is_normal);   // Subnormal scale is 1
    e_prod = (info_a.is_zero || info_b.is_zero) ? 2 - BIAS          // Zero product, min exp
           : int'(operand_a.exponent) + int'(info_a.is_subnormal)
             + int'(operand_b.exponent) + int'(info_b.is_subnormal) - BIAS;
    e_diff = e_add - e_prod;
    exp_product = EXP_WIDTH'(e_prod);
    exp_diff    = EXP_WIDTH'(e_diff);
    tent_exp    = EXP_WIDTH'((e_diff > 0) ? e_add : e_prod);
    if (e_diff <= -2 * PREC_BITS - 1) begin
      addend_shamt = SHAMT_WIDTH'(3 * PREC_BITS + 4);   // Addend only in sticky
    end else if (e_diff <= PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PREC_BITS + 3 - e_diff);
    end else begin
      addend_shamt = '0;                                // Product only in sticky
    end
  end

  // ------------------------------------------------------------------------
  // Product, aligned addend and sum
  // ------------------------------------------------------------------------
  logic [PREC_BITS-1:0]   man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0] product;
  logic [SUM_WIDTH-1:0]   product_shifted, addend_after_shift, addend_shifted, sum;
  logic [PREC_BITS-1:0]   addend_sticky_bits;
  logic                   sticky_before_add, inject_carry;
  logic [SUM_WIDTH:0]     sum_raw;                      // Extra carry bit

  assign man_a   = {info_a.is_normal, operand_a.mantissa};
  assign man_b   = {info_b.is_normal, operand_b.mantissa};
  assign man_c   = {info_c.is_normal, operand_c.mantissa};
  assign product = man_a * man_b;
  assign product_shifted = {{(PREC_BITS+2){1'b0}}, product, 2'b00};   // p+2 pad, G/R

  // Up to p bits fall off the right into the sticky field
  assign {addend_after_shift, addend_sticky_bits} = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;
  assign addend_shifted    = eff_sub ? ~addend_after_shift : addend_after_shift;
  assign inject_carry      = eff_sub & !sticky_before_add;  // Completes two's complement

  assign sum_raw = product_shifted + addend_shifted + inject_carry;
  // No carry on a subtraction means a negative sum
  assign sum = (eff_sub && !sum_raw[SUM_WIDTH]) ? SUM_WIDTH'(-sum_raw) : sum_raw[SUM_WIDTH-1:0];

  always_comb begin : pack_mid
    mid_o = '{
      eff_sub:           eff_sub,
      final_sign:        eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign,
      exp_product:       exp_product,
      exp_diff:          exp_diff,
      tent_exp:          tent_exp,
      addend_shamt:      addend_shamt,
      sticky_before_add: sticky_before_add,
      sum:               sum,
      rnd_mode:          req_i.rnd_mode,
      is_special:        is_special,
      special_result:    special_result,
      special_status:    special_status,
      tag:               req_i.tag
    };
  end

endmodule

//--- src/fma_norm_round.sv
/*
 * FMA back end
 * Leading-zero normalization, rounding, status flags and selection
 * between the special and the regular result
 */
`timescale 1ns/10ps

module fma_norm_round
  import fp_pkg::*;
  import fma_pkg::*;
(
  input  fma_mid_t mid_i,
  output fma_rsp_t rsp_o
);

  localparam int LOWER_WIDTH = 2 * PREC_BITS + 3;   // Cancellation window
  localparam int LZC_WIDTH   = $clog2(LOWER_WIDTH);

  // ------------------------------------------------------------------------
  // Leading-zero count
  // ------------------------------------------------------------------------
  logic [LOWER_WIDTH-1:0] sum_lower;
  logic [LZC_WIDTH-1:0]   lz_count;
  logic                   lz_empty;                 // No one in the window

  assign sum_lower = mid_i.sum[LOWER_WIDTH-1:0];

  always_comb begin : lzc
    lz_count = '0;
    lz_empty = 1'b1;
    for (int i = 0; i < LOWER_WIDTH; i++) begin
      if (lz_empty && sum_lower[LOWER_WIDTH-1-i]) begin
        lz_count = LZC_WIDTH'(i);                   // First one from the top
        lz_empty = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Normalization
  // ------------------------------------------------------------------------
  logic [SHAMT_WIDTH-1:0] norm_shamt;
  logic [SUM_WIDTH:0]     sum_shifted;               // Carry bit on top
  logic [PREC_BITS:0]     final_mantissa;            // Hidden bit down to round bit
  logic [2*PREC_BITS+2:0] sum_sticky_bits;
  int                     norm_exp, final_exp;

  always_comb begin : norm_shift_amount
    int e_prod;
    int e_diff;
    int lz;
    e_prod = int'($signed(mid_i.exp_product));
    e_diff = int'($signed(mid_i.exp_diff));
    lz     = int'(lz_count);
    if ((e_diff <= 0) || (mid_i.eff_sub && (e_diff <= 2))) begin
      if ((e_prod - lz + 1 >= 0) && !lz_empty) begin
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + lz);          // Product anchored
        norm_exp   = e_prod - lz + 1;
      end else begin
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + e_prod);      // Capped at min exponent
        norm_exp   = 0;
      end
    end else begin
      norm_shamt = mid_i.addend_shamt;                          // Addend anchored
      norm_exp   = int'($signed(mid_i.tent_exp));
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // One-bit correction, leading one may sit either side of the sum MSB
  always_comb begin : small_norm
    {final_mantissa, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_mantissa, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;                                     // Already normal
    end else if (norm_exp > 1) begin
      {final_mantissa, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp = norm_exp - 1;
    end else begin
      final_exp = 0;                                            // Subnormal
    end
  end

  // ------------------------------------------------------------------------
  // Rounding
  // ------------------------------------------------------------------------
  logic                         of_before_round;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs, rounded_abs;
  logic [1:0]                   round_sticky;
  logic                         round_up, exact_zero, rounded_sign;
  logic                         uf_after_round, of_after_round;
  status_t                      regular_status;

  assign of_before_round = final_exp >= 2**EXP_BITS - 1;
  // Saturate to the largest normal value on overflow
  assign pre_round_abs = of_before_round ? {{(EXP_BITS-1){1'b1}}, 1'b0, {MAN_BITS{1'b1}}}
                                         : {EXP_BITS'(final_exp), final_mantissa[MAN_BITS:1]};
  assign round_sticky[1] = final_mantissa[0] | of_before_round;
  assign round_sticky[0] = (|sum_sticky_bits) | mid_i.sticky_before_add | of_before_round;

  always_comb begin : round_decision
    case (mid_i.rnd_mode)
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & mid_i.final_sign;
      RUP:     round_up = (|round_sticky) & !mid_i.final_sign;
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs  = pre_round_abs + round_up;          // Carry may bump exponent
  assign exact_zero   = (pre_round_abs == '0) && (round_sticky == 2'b00);
  // Exact zero from x - x is -0 only under RDN
  assign rounded_sign = (exact_zero && mid_i.eff_sub) ? (mid_i.rnd_mode == RDN)
                                                      : mid_i.final_sign;

  assign uf_after_round = rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0;
  assign of_after_round = rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1;

  assign regular_status.NV = 1'b0;
  assign regular_status.DZ = 1'b0;
  assign regular_status.OF = of_before_round | of_after_round;
  assign regular_status.UF = uf_after_round & regular_status.NX;   // Tiny and inexact
  assign regular_status.NX = (|round_sticky) | of_before_round | of_after_round;

  // Result selection
  assign rsp_o.result = mid_i.is_special ? mid_i.special_result
                                         : {rounded_sign, rounded_abs};
  assign rsp_o.status = mid_i.is_special ? mid_i.special_status : regular_status;
  assign rsp_o.tag    = mid_i.tag;

endmodule

//--- src/fma_unit.sv
/*
 * Single-precision FMA unit
 * Front end, mid register, normalize/round and output register
 */
`timescale 1ns/10ps

module fma_unit
  import fma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  fma_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output fma_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  fma_mid_t mid_d, mid_q;
  logic     mid_valid;            // Item held after the adder
  logic     mid_ready;            // Output stage can take it
  fma_rsp_t rsp_d;

  fma_prep u_prep (
    .req_i ( req_i ),
    .mid_o ( mid_d )
  );

  fma_pipe_reg #(
    .T ( fma_mid_t )
  ) u_mid_reg (
    .clk_i,
    .rst_n_i,
    .data_i  ( mid_d      ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_o  ( mid_q      ),
    .valid_o ( mid_valid  ),
    .ready_i ( mid_ready  )
  );

  fma_norm_round u_norm_round (
    .mid_i ( mid_q ),
    .rsp_o ( rsp_d )
  );

  fma_pipe_reg #(
    .T ( fma_rsp_t )
  ) u_out_reg (
    .clk_i,
    .rst_n_i,
    .data_i  ( rsp_d       ),
    .valid_i ( mid_valid   ),
    .ready_o ( mid_ready   ),
    .data_o  ( rsp_o       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i )
  );

  assign busy_o = mid_valid | out_valid_o;  // Either stage occupied

endmodule

//--- sim/fma_assert.sv
/*
 * FMA unit handshake checks
 * Output hold under back-pressure, reset state and busy coverage
 */
`timescale 1ns/10ps

module fma_assert
  import fma_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     in_valid_i,
  input logic     in_ready_o,
  input fma_rsp_t rsp_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input logic     busy_o
);

  int fail_count = 0;                           // Failed properties so far

  // Stalled response holds until taken
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
  else begin
    $error("response changed while out_ready_i low");
    fail_count++;
  end

  // No request offered during reset
  assert property (@(posedge clk_i) !rst_n_i |-> !in_valid_i)
  else begin
    $error("in_valid_i high during reset");
    fail_count++;
  end

  // Output stage empty once reset has been seen
  assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
  else begin
    $error("out_valid_o high after a reset edge");
    fail_count++;
  end

  // Occupied while a response waits and after each accepted request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o || $past(in_valid_i && in_ready_o) |-> busy_o)
  else begin
    $error("busy_o low with an item in flight");
    fail_count++;
  end

endmodule

bind fma_unit fma_assert u_fma_assert (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .rsp_o       ( rsp_o       ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_o      ( busy_o      )
);

//--- sim/fma_tb.sv
/*
 * FMA unit testbench
 * Directed tests for exact arithmetic, special cases, rounding modes,
 * subnormal results and a back-pressured stream
 */
`timescale 1ns/10ps
`include "fma_cfg.svh"

module fma_tb
  import fp_pkg::*;
  import fma_pkg::*;
();

  localparam int STREAM_LEN      = 30;
  localparam int NUM_REQS        = 32 + 5 + 12 + 4 + STREAM_LEN;
  localparam int WATCHDOG_CYCLES = NUM_REQS * 10 + 200;   // Ten cycles per request, plus slack

  localparam logic [31:0] F_ONE      = 32'h3F80_0000;
  localparam logic [31:0] F_TWO      = 32'h4000_0000;
  localparam logic [31:0] F_POS_INF  = 32'h7F80_0000;
  localparam logic [31:0] F_NEG_INF  = 32'hFF80_0000;
  localparam logic [31:0] F_QNAN     = 32'h7FC0_0000;
  localparam logic [31:0] F_SNAN     = 32'h7FA0_0000;     // Mantissa MSB clear
  localparam logic [31:0] F_MAX_NORM = 32'h7F7F_FFFF;
  localparam logic [31:0] F_MIN_SUB  = 32'h0000_0001;
  localparam logic [31:0] F_NEG_ZERO = 32'h8000_0000;
  localparam logic [31:0] F_HALF_ULP = 32'h3380_0000;     // 2^-24, half an ulp of 1.0
  localparam logic [31:0] F_3Q_ULP   = 32'h33C0_0000;     // 3 * 2^-25
  localparam logic [31:0] F_TINY     = 32'h0D80_0000;     // 2^-100

  localparam status_t ST_NONE  = 5'b00000;
  localparam status_t ST_NV    = 5'b10000;
  localparam status_t ST_OF_NX = 5'b00101;
  localparam status_t ST_UF_NX = 5'b00011;
  localparam status_t ST_NX    = 5'b00001;

  logic                      clk = 1'b0;
  logic                      rst_n;
  fma_req_t                  req;
  logic                      in_valid, in_ready;
  fma_rsp_t                  rsp;
  logic                      out_valid, out_ready, busy;
  logic [15:0]               lfsr_state = 16'd39261;
  logic [`FMA_TAG_WIDTH-1:0] next_tag = '0;
  int                        errors = 0;
  int                        checks = 0;

  fma_unit uut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_i       ( req       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .rsp_o       ( rsp       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  always #20 clk = !clk;                        // 40 ns period

  // --------------------------------------------------------------------------
  // Stimulus and reference helpers
  // --------------------------------------------------------------------------
  function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];                        // Galois form, taps 16,14,13,11
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(next_bit());
    return v;
  endfunction

  // Nonzero operand, so a zero result only comes from cancellation
  function automatic longint draw_small_int();
    longint mag;
    mag = longint'(draw_bits(10));
    if (mag == 0) mag = 1;
    return next_bit() ? -mag : mag;
  endfunction

  function automatic logic [31:0] int_to_fp(input longint v);
    longint      mag;
    int          msb;
    logic [31:0] f;
    if (v == 0) return 32'h0;
    mag = (v < 0) ? -v : v;
    msb = 0;
    for (int i = 0; i < 32; i++) if (mag[i]) msb = i;
    f[31]    = (v < 0);
    f[30:23] = 8'(`FMA_BIAS + msb);
    f[22:0]  = 23'(mag << (`FMA_MAN_BITS - msb));   // Hidden bit drops off the top
    return f;
  endfunction

  // Ulps above 1.0 after rounding the positive value 1.0 + q/4 ulp, 0 < q < 4
  function automatic int round_quarter_ulps(input roundmode_e m, input int q);
    case (m)
      RNE:     return (q > 2) ? 1 : 0;          // Tie goes to 1.0, the even neighbour
      RMM:     return (q >= 2) ? 1 : 0;         // Tie goes away from zero
      RUP:     return (q > 0) ? 1 : 0;
      default: return 0;                        // RTZ and RDN drop the fraction of a positive
    endcase
  endfunction

  task automatic make_exact(input fma_op_e op, input logic op_mod, input roundmode_e mode,
                            output fma_req_t r, output fma_rsp_t exp);
    longint a, b, c, prod, addend, value;
    a = draw_small_int();
    b = draw_small_int();
    c = draw_small_int();
    case (op)
      FMADD:   prod = a * b;
      FNMSUB:  prod = -(a * b);
      ADD:     prod = b;                        // A taken as 1.0
      default: prod = a * b;
    endcase
    addend = (op == MUL) ? 0 : (op_mod ? -c : c);
    value  = prod + addend;                     // Below 2^21, exact in binary32
    r.operands[0] = int_to_fp(a);
    r.operands[1] = int_to_fp(b);
    r.operands[2] = int_to_fp(c);
    r.op          = op;
    r.op_mod      = op_mod;
    r.rnd_mode    = mode;
    r.tag         = next_tag;
    next_tag      = next_tag + 1'b1;
    exp.result = (value != 0) ? int_to_fp(value) : ((mode == RDN) ? F_NEG_ZERO : 32'h0);
    exp.status = ST_NONE;
    exp.tag    = r.tag;
  endtask

  // --------------------------------------------------------------------------
  // Handshake and checks
  // --------------------------------------------------------------------------
  task automatic run_req(input fma_req_t r, output fma_rsp_t got);
    @(negedge clk);
    req       = r;
    in_valid  = 1'b1;
    out_ready = 1'b1;
    #1;
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);                             // Taken on the edge just passed
    in_valid = 1'b0;
    #1;
    while (!out_valid) begin
      @(negedge clk);
      #1;
    end
    got = rsp;
  endtask

  task automatic check_rsp(input string what, input fma_rsp_t got, input fma_rsp_t exp);
    checks++;
    assert (got.result == exp.result) else begin
      $display("CHECK FAILED rsp_o.result (%s): got %h, expected %h", what, got.result,
               exp.result);
      errors++;
    end
    assert (got.status == exp.status) else begin
      $display("CHECK FAILED rsp_o.status (%s): got %h, expected %h", what, got.status,
               exp.status);
      errors++;
    end
    assert (got.tag == exp.tag) else begin
      $display("CHECK FAILED rsp_o.tag (%s): got %h, expected %h", what, got.tag, exp.tag);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic send_check(input string what, input logic [31:0] a, b, c,
                            input fma_op_e op, input logic op_mod, input roundmode_e mode,
                            input logic [31:0] exp_result, input status_t exp_status);
    fma_req_t r;
    fma_rsp_t got;
    fma_rsp_t exp;
    r.operands[0] = a;
    r.operands[1] = b;
    r.operands[2] = c;
    r.op          = op;
    r.op_mod      = op_mod;
    r.rnd_mode    = mode;
    r.tag         = next_tag;
    next_tag      = next_tag + 1'b1;
    exp.result    = exp_result;
    exp.status    = exp_status;
    exp.tag       = r.tag;
    run_req(r, got);
    check_rsp(what, got, exp);
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %-18s %0d errors", name, errors - start);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_reset_state();
    int start;
    start = errors;
    #1;
    check_level("out_valid_o", out_valid, 1'b0);
    check_level("busy_o", busy, 1'b0);
    check_level("in_ready_o", in_ready, 1'b1);
    report_test("reset_state", start);
  endtask

  task automatic test_exact();
    int       start;
    fma_req_t r;
    fma_rsp_t exp, got;
    start = errors;
    for (int k = 0; k < 4; k++) begin
      for (int o = 0; o < 4; o++) begin
        for (int m = 0; m < 2; m++) begin           // Every op with and without modifier
          make_exact(fma_op_e'(o), m[0], roundmode_e'((2 * o + m + k) % 5), r, exp);
          run_req(r, got);
          check_rsp("exact", got, exp);
        end
      end
    end
    report_test("exact_arith", start);
  endtask

  task automatic test_special();
    int start;
    start = errors;
    send_check("inf*0+qnan", F_POS_INF, 32'h0, F_QNAN, FMADD, 1'b0, RNE, F_QNAN, ST_NV);
    send_check("snan", F_SNAN, F_ONE, F_ONE, FMADD, 1'b0, RNE, F_QNAN, ST_NV);
    send_check("qnan", F_QNAN, F_ONE, F_ONE, FMADD, 1'b0, RNE, F_QNAN, ST_NONE);
    send_check("inf-inf", F_POS_INF, F_ONE, F_POS_INF, FMADD, 1'b1, RNE, F_QNAN, ST_NV);
    send_check("-inf*2", F_NEG_INF, F_TWO, 32'h0, MUL, 1'b0, RNE, F_NEG_INF, ST_NONE);
    report_test("special_cases", start);
  endtask

  task automatic test_rounding();
    int         start;
    roundmode_e md;
    start = errors;
    for (int m = 0; m < 5; m++) begin
      md = roundmode_e'(m);
      // Half and three quarters of an ulp above 1.0
      send_check($sformatf("tie %s", md.name()), F_ONE, F_ONE, F_HALF_ULP, ADD, 1'b0, md,
                 F_ONE + 32'(round_quarter_ulps(md, 2)), ST_NX);
      send_check($sformatf("3/4 ulp %s", md.name()), F_ONE, F_ONE, F_3Q_ULP, ADD, 1'b0, md,
                 F_ONE + 32'(round_quarter_ulps(md, 3)), ST_NX);
    end
    send_check("max*2 RNE", F_MAX_NORM, F_TWO, 32'h0, MUL, 1'b0, RNE, F_POS_INF, ST_OF_NX);
    send_check("max*2 RTZ", F_MAX_NORM, F_TWO, 32'h0, MUL, 1'b0, RTZ, F_MAX_NORM, ST_OF_NX);
    report_test("rounding_modes", start);
  endtask

  task automatic test_subnormal();
    int          start;
    logic [31:0] five;
    start = errors;
    five  = int_to_fp(5);
    send_check("tiny*tiny RNE", F_TINY, F_TINY, 32'h0, MUL, 1'b0, RNE, 32'h0, ST_UF_NX);
    send_check("tiny*tiny RUP", F_TINY, F_TINY, 32'h0, MUL, 1'b0, RUP, F_MIN_SUB, ST_UF_NX);
    send_check("x-x RNE", F_ONE, five, five, ADD, 1'b1, RNE, 32'h0, ST_NONE);
    send_check("x-x RDN", F_ONE, five, five, ADD, 1'b1, RDN, F_NEG_ZERO, ST_NONE);
    report_test("subnormal_zero", start);
  endtask

  task automatic test_stream();
    fma_req_t reqs[STREAM_LEN];
    fma_rsp_t exps[STREAM_LEN];
    int       start, sent, received;
    start    = errors;
    sent     = 0;
    received = 0;
    for (int i = 0; i < STREAM_LEN; i++) begin
      make_exact(fma_op_e'(draw_bits(2)), next_bit(), roundmode_e'(draw_bits(3) % 5),
                 reqs[i], exps[i]);
    end
    while (received < STREAM_LEN) begin
      @(negedge clk);
      in_valid = (sent < STREAM_LEN);           // Offer held until taken
      if (sent < STREAM_LEN) req = reqs[sent];
      out_ready = next_bit();
      #1;
      if (out_valid && out_ready) begin         // Taken at the coming edge
        check_rsp($sformatf("stream %0d", received), rsp, exps[received]);
        received++;
      end
      if (in_valid && in_ready) sent++;
    end
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    #1;
    check_level("out_valid_o", out_valid, 1'b0);  // Nothing duplicated
    check_level("busy_o", busy, 1'b0);
    report_test("backpressure", start);
  endtask

  // --------------------------------------------------------------------------
  // Sequence and verdict
  // --------------------------------------------------------------------------
  initial begin : main
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    req       = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_exact();
    test_special();
    test_rounding();
    test_subnormal();
    test_stream();
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             uut.u_fma_assert.fail_count);
    if (errors == 0 && uut.u_fma_assert.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+include
src/fp_pkg.sv
src/fma_pkg.sv
src/fp_classifier.sv
src/fma_pipe_reg.sv
src/fma_prep.sv
src/fma_norm_round.sv
src/fma_unit.sv
sim/fma_assert.sv
sim/fma_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the FMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fma_tb -f build.f -o fma_sim

# Keep running past failed assertions so the testbench prints its verdict
output=$(./obj_dir/fma_sim +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
